// File: Makefile
SIM    = verilator
FLAGS  = --binary --timing -j 0
TOP    = tb_trace_core
FLIST  = all.f
OBJDIR = obj_dir
LOG    = sim.log
BIN    = $(OBJDIR)/V$(TOP)
SRCS   = $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: all.f
verilog/pipe_pkg.sv
verilog/pipeline_tracker.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/trace_core.sv
test/trace_checker.sv
test/tb_trace_core.sv

// File: test/tb_trace_core.sv
`timescale 1ns/1ps

module tb_trace_core import pipe_pkg::*; ();

    localparam int reset_len = 3;
    localparam int rand_len = 400;
    localparam int drain_len = 16;
    // reset, directed li, random, drain, slack
    localparam int timeout_lim = reset_len + reg_cnt + rand_len + drain_len + 50;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    logic [word_w-1:0]  instr;
    logic               stall;
    logic               flush;
    logic               retire_valid;
    logic [addr_w-1:0]  retire_rd;
    logic [word_w-1:0]  retire_data;
    logic               retire_we;
    logic [seq_w-1:0]   retire_seq;
    logic [stamp_w-1:0] retire_issue;
    logic [stamp_w-1:0] retire_cycle;
    int                 err_cnt;
    int                 ret_cnt;
    logic               pipe_empty;
    // fibonacci lfsr, taps 32 22 2 1
    logic [31:0]        lfsr_q = 32'h8f35_d42e;
    int                 cyc = 0;

    trace_core dut0 (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .stall(stall),
        .flush(flush), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_we(retire_we), .retire_seq(retire_seq),
        .retire_issue(retire_issue), .retire_cycle(retire_cycle)
    );

    // watches the ports, keeps the model
    trace_checker check0 (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .stall(stall),
        .flush(flush), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_we(retire_we), .retire_seq(retire_seq),
        .retire_issue(retire_issue), .retire_cycle(retire_cycle),
        .err_cnt(err_cnt), .ret_cnt(ret_cnt), .pipe_empty(pipe_empty)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= timeout_lim) begin
            $display("timeout: run did not finish within %0d cycles", timeout_lim);
            $display("Test FAILED");
            $finish;
        end
    end

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    ////////////////////
    // random stimulus
    ////////////////////

    // opcodes weighted toward alu, li, addi
    task automatic random_cycle();
        logic [31:0]     pick;
        logic [op_w-1:0] opc;
        pick = take_bits(4);
        if (pick < 6) begin
            opc = op_alu;
        end else if (pick < 10) begin
            opc = op_li;
        end else if (pick < 14) begin
            opc = op_addi;
        end else begin
            opc = 4'(take_bits(4));
        end
        instr = {opc, 12'(take_bits(12))};
        // roughly 70, 15 and 4 percent
        instr_valid = (take_bits(7) < 90);
        stall = (take_bits(7) < 19);
        flush = (take_bits(7) < 5);
    endtask

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (reset_len) next_cycle();
        rst = 1'b0;
        // every register gets a known value, r7 negative
        for (int r = 0; r < reg_cnt; r++) begin
            instr_valid = 1'b1;
            instr = {op_li, 3'(r), 9'(r * 37 + 5)};
            next_cycle();
        end
        repeat (rand_len) begin
            random_cycle();
            next_cycle();
        end
        // drain until the model and the dut are empty
        instr_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        while (!pipe_empty || retire_valid) begin
            next_cycle();
        end
        next_cycle();
        $display("errors: %0d, retired: %0d", err_cnt, ret_cnt);
        if (err_cnt == 0 && ret_cnt > 0) begin
            $display("Test OK");
        end else begin
            if (ret_cnt == 0) begin
                $display("no instruction retired during the run");
            end
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: test/trace_checker.sv
`timescale 1ns/1ps

module trace_checker import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [word_w-1:0]  instr,
    input  logic               stall,
    input  logic               flush,
    input  logic               retire_valid,
    input  logic [addr_w-1:0]  retire_rd,
    input  logic [word_w-1:0]  retire_data,
    input  logic               retire_we,
    input  logic [seq_w-1:0]   retire_seq,
    input  logic [stamp_w-1:0] retire_issue,
    input  logic [stamp_w-1:0] retire_cycle,
    output int                 err_cnt,
    output int                 ret_cnt,
    output logic               pipe_empty
);

    // shadow pipe, slot 0 decode, 1 execute, 2 result
    logic               s_valid [3];
    logic [word_w-1:0]  s_word [3];
    logic [seq_w-1:0]   s_seq [3];
    logic [stamp_w-1:0] s_issue [3];
    int                 s_stalls [3];
    // outcome of the record sitting in slot 2
    logic [addr_w-1:0]  r_rd;
    logic [word_w-1:0]  r_data;
    logic               r_we;
    // sequential machine
    logic [word_w-1:0]  m_regs [reg_cnt];
    logic [seq_w-1:0]   m_seq;
    logic [stamp_w-1:0] m_cycle;
    // next id due at retire, killed ids are skipped
    logic [seq_w-1:0]   expect_seq;
    logic               killed [256];
    logic               live = 1'b0;
    int                 errors = 0;
    int                 retired = 0;

    assign err_cnt = errors;
    assign ret_cnt = retired;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////
    // reference execution
    ////////////////////

    // one surviving word, in program order
    task automatic run_sequential(input logic [word_w-1:0] w);
        logic [word_w-1:0] a;
        logic [word_w-1:0] b;
        logic [word_w-1:0] imm;
        a = m_regs[w[8:6]];
        b = m_regs[w[5:3]];
        imm = {{(word_w-9){w[8]}}, w[8:0]};
        r_rd = w[11:9];
        r_we = 1'b1;
        r_data = '0;
        case (w[15:12])
            op_alu: begin
                case (w[2:0])
                    fn_add: r_data = a + b;
                    fn_sub: r_data = a - b;
                    fn_and: r_data = a & b;
                    fn_or: r_data = a | b;
                    fn_xor: r_data = a ^ b;
                    // unknown funct writes zero
                    default: r_data = '0;
                endcase
            end
            op_li: r_data = imm;
            op_addi: r_data = m_regs[w[11:9]] + imm;
            // nop
            default: r_we = 1'b0;
        endcase
        if (r_we) begin
            m_regs[w[11:9]] = r_data;
        end
    endtask

    // slot k takes over slot k-1, a flush kills the mover
    task automatic shift_slot(input int k, input logic kill);
        if (s_valid[k-1] && kill) begin
            killed[s_seq[k-1]] = 1'b1;
        end
        s_valid[k] = s_valid[k-1] && !kill;
        s_word[k] = s_word[k-1];
        s_seq[k] = s_seq[k-1];
        s_issue[k] = s_issue[k-1];
        s_stalls[k] = s_stalls[k-1];
    endtask

    ////////////////////
    // per cycle compare and predict
    ////////////////////

    // negedge, inputs and outputs both settled
    always @(negedge clk) begin
        logic [stamp_w-1:0] span;
        logic               accept;
        if (rst) begin
            for (int k = 0; k < 256; k++) begin
                killed[k] = 1'b0;
            end
            for (int k = 0; k < reg_cnt; k++) begin
                m_regs[k] = '0;
            end
            for (int k = 0; k < 3; k++) begin
                s_valid[k] = 1'b0;
                s_stalls[k] = 0;
            end
            m_seq = '0;
            m_cycle = '0;
            expect_seq = '0;
            live = 1'b1;
        end else if (live) begin
            check_value("retire_valid", 32'(retire_valid), 32'(s_valid[2]));
            check_value("retire_cycle", 32'(retire_cycle), 32'(m_cycle));
            if (retire_valid && s_valid[2]) begin
                check_value("retire_rd", 32'(retire_rd), 32'(r_rd));
                check_value("retire_we", 32'(retire_we), 32'(r_we));
                if (r_we) begin
                    check_value("retire_data", 32'(retire_data), 32'(r_data));
                end
                check_value("retire_seq", 32'(retire_seq), 32'(s_seq[2]));
                check_value("retire_issue", 32'(retire_issue), 32'(s_issue[2]));
                // leaves at the coming edge, held records count once
                if (!stall) begin
                    retired++;
                    for (int k = 0; k < 256 && killed[expect_seq]; k++) begin
                        killed[expect_seq] = 1'b0;
                        expect_seq++;
                    end
                    check_value("seq order", 32'(retire_seq), 32'(expect_seq));
                    expect_seq++;
                    span = retire_cycle - retire_issue;
                    check_value("issue to retire span", 32'(span), 32'(s_stalls[2] + 2));
                end
            end
            // what the coming edge does
            accept = instr_valid && !stall;
            if (!stall) begin
                shift_slot(2, flush);
                if (s_valid[2]) begin
                    run_sequential(s_word[2]);
                end
                shift_slot(1, flush);
                s_valid[0] = accept;
                s_word[0] = instr;
                s_seq[0] = m_seq;
                // stamp seen after the accepting edge
                s_issue[0] = m_cycle + 1'b1;
                s_stalls[0] = 0;
            end else begin
                for (int k = 0; k < 3; k++) begin
                    if (s_valid[k]) begin
                        s_stalls[k]++;
                    end
                end
                // young stages die in place, result holds
                for (int k = 0; k < 2; k++) begin
                    if (flush && s_valid[k]) begin
                        killed[s_seq[k]] = 1'b1;
                    end
                    s_valid[k] = s_valid[k] && !flush;
                end
            end
            if (accept) begin
                m_seq++;
            end
            m_cycle++;
        end
        pipe_empty = !(s_valid[0] || s_valid[1] || s_valid[2]);
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic              accept,
    input  logic [word_w-1:0] instr,
    input  logic              exe_valid,
    input  logic              res_valid,
    input  logic [word_w-1:0] alu_fwd,
    input  logic [addr_w-1:0] exe_rd,
    input  logic              exe_we,
    input  logic [word_w-1:0] res_data,
    input  logic [addr_w-1:0] res_rd,
    input  logic              res_we,
    output logic [addr_w-1:0] rf_addr_a,
    output logic [addr_w-1:0] rf_addr_b,
    input  logic [word_w-1:0] rf_data_a,
    input  logic [word_w-1:0] rf_data_b,
    output logic [word_w-1:0] op_a,
    output logic [word_w-1:0] op_b,
    output logic [fn_w-1:0]   alu_fn,
    output logic [addr_w-1:0] dst,
    output logic              write_en
);

    // instruction register seen through two views
    instr_u            ir;
    logic [word_w-1:0] imm_ext;
    logic [word_w-1:0] src_a;
    logic [word_w-1:0] src_b;

    // youngest producer wins
    function automatic logic [word_w-1:0] fwd_pick(
        input logic [addr_w-1:0] src,
        input logic [word_w-1:0] rf_val
    );
        logic [word_w-1:0] val;
        if (exe_valid && exe_we && exe_rd == src) begin
            val = alu_fwd;
        end else if (res_valid && res_we && res_rd == src) begin
            val = res_data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    ////////////////////
    // capture
    ////////////////////

    // empty slots carry a nop so write_en stays low
    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= bubble_word;
        end else if (advance) begin
            ir <= accept ? instr : bubble_word;
        end
    end

    ////////////////////
    // operand fetch
    ////////////////////

    // addi reads its own rd as the first source
    assign rf_addr_a = (ir.reg_form.opcode == op_addi) ? ir.imm_form.rd : ir.reg_form.rs1;
    assign rf_addr_b = ir.reg_form.rs2;

    // bypass state is read inside fwd_pick
    always_comb begin
        src_a = fwd_pick(rf_addr_a, rf_data_a);
        src_b = fwd_pick(rf_addr_b, rf_data_b);
    end

    assign imm_ext = {{(word_w-imm_w){ir.imm_form.imm9[imm_w-1]}}, ir.imm_form.imm9};

    // rd sits in the same bits for both forms
    assign dst = ir.reg_form.rd;

    always_comb begin
        op_a = '0;
        op_b = '0;
        alu_fn = fn_add;
        write_en = 1'b0;
        case (ir.reg_form.opcode)
            op_alu: begin
                op_a = src_a;
                op_b = src_b;
                alu_fn = ir.reg_form.funct;
                write_en = 1'b1;
            end
            // zero plus immediate
            op_li: begin
                op_b = imm_ext;
                write_en = 1'b1;
            end
            op_addi: begin
                op_a = src_a;
                op_b = imm_ext;
                write_en = 1'b1;
            end
            // nop writes nothing
            default: write_en = 1'b0;
        endcase
    end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic [word_w-1:0] op_a,
    input  logic [word_w-1:0] op_b,
    input  logic [fn_w-1:0]   alu_fn,
    input  logic [addr_w-1:0] dst,
    input  logic              write_en,
    output logic [word_w-1:0] alu_fwd,
    output logic [addr_w-1:0] exe_rd,
    output logic              exe_we,
    output logic [word_w-1:0] res_data,
    output logic [addr_w-1:0] res_rd,
    output logic              res_we
);

    // operands latched from decode
    logic [word_w-1:0] ex_a;
    logic [word_w-1:0] ex_b;
    logic [fn_w-1:0]   ex_fn;

    ////////////////////
    // execute registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_a <= op_a;
            ex_b <= op_b;
            ex_fn <= alu_fn;
            exe_rd <= dst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_we <= 1'b0;
            res_we <= 1'b0;
        end else if (advance) begin
            exe_we <= write_en;
            res_we <= exe_we;
        end
    end

    ////////////////////
    // alu
    ////////////////////

    // also the forwarding source for decode
    always_comb begin
        case (ex_fn)
            fn_add: alu_fwd = ex_a + ex_b;
            fn_sub: alu_fwd = ex_a - ex_b;
            fn_and: alu_fwd = ex_a & ex_b;
            fn_or: alu_fwd = ex_a | ex_b;
            fn_xor: alu_fwd = ex_a ^ ex_b;
            // undefined functs still write, as zero
            default: alu_fwd = '0;
        endcase
    end

    // result register, shown at retire
    always_ff @(posedge clk) begin
        if (advance) begin
            res_data <= alu_fwd;
            res_rd <= exe_rd;
        end
    end

endmodule

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    ////////////////////
    // widths
    ////////////////////

    // data and instruction word
    localparam int word_w = 16;
    // register file depth, r0 is an ordinary register
    localparam int reg_cnt = 8;
    localparam int addr_w = $clog2(reg_cnt);
    // sequence ids wrap at 256
    localparam int seq_w = 8;
    // cycle stamps wrap at 64k
    localparam int stamp_w = 16;
    localparam int op_w = 4;
    localparam int fn_w = 3;
    localparam int imm_w = 9;

    ////////////////////
    // encodings
    ////////////////////

    // opcodes, anything else is a nop
    localparam logic [op_w-1:0] op_alu = 4'd0;
    localparam logic [op_w-1:0] op_li = 4'd1;
    localparam logic [op_w-1:0] op_addi = 4'd2;

    // alu functs for register form
    localparam logic [fn_w-1:0] fn_add = 3'd0;
    localparam logic [fn_w-1:0] fn_sub = 3'd1;
    localparam logic [fn_w-1:0] fn_and = 3'd2;
    localparam logic [fn_w-1:0] fn_or = 3'd3;
    localparam logic [fn_w-1:0] fn_xor = 3'd4;

    // unused opcode, loaded into decode for bubbles
    localparam logic [word_w-1:0] bubble_word = 16'hf000;

    ////////////////////
    // instruction views
    ////////////////////

    // rd = rs1 op rs2
    typedef struct packed {
        logic [op_w-1:0]   opcode;
        logic [addr_w-1:0] rd;
        logic [addr_w-1:0] rs1;
        logic [addr_w-1:0] rs2;
        logic [fn_w-1:0]   funct;
    } rform_t;

    // rd = imm or rd + imm
    typedef struct packed {
        logic [op_w-1:0]   opcode;
        logic [addr_w-1:0] rd;
        logic [imm_w-1:0]  imm9;
    } iform_t;

    // same 16 bits, opcode and rd line up in both
    typedef union packed {
        rform_t reg_form;
        iform_t imm_form;
    } instr_u;

endpackage

// File: verilog/pipeline_tracker.sv
`timescale 1ns/1ps

module pipeline_tracker import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               accept,
    input  logic               stall,
    input  logic               flush,
    output logic               advance,
    output logic               dec_valid,
    output logic               exe_valid,
    output logic               res_valid,
    output logic [seq_w-1:0]   ret_seq,
    output logic [stamp_w-1:0] ret_issue,
    output logic [stamp_w-1:0] ret_cycle
);

    // free running, counts stalled cycles too
    logic [stamp_w-1:0] cycle_cnt;
    // next id to hand out
    logic [seq_w-1:0]   seq_cnt;

    // tags riding beside the valid bits
    logic [seq_w-1:0]   dec_seq;
    logic [seq_w-1:0]   exe_seq;
    logic [stamp_w-1:0] dec_issue;
    logic [stamp_w-1:0] exe_issue;

    // whole pipe moves or whole pipe holds
    assign advance = ~stall;

    ////////////////////
    // counters and valid chain
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
            seq_cnt <= '0;
            dec_valid <= 1'b0;
            exe_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            // flushed instructions still burn their id
            if (accept) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
            if (advance) begin
                // a new word enters decode even on a flush edge
                dec_valid <= accept;
                // killed ones do not move forward
                exe_valid <= dec_valid & ~flush;
                res_valid <= exe_valid & ~flush;
            end else if (flush) begin
                // stalled flush, young stages die in place
                dec_valid <= 1'b0;
                exe_valid <= 1'b0;
            end
        end
    end

    ////////////////////
    // tag chain
    ////////////////////

    always_ff @(posedge clk) begin
        if (advance) begin
            dec_seq <= seq_cnt;
            // stamp is the first cycle spent in decode
            dec_issue <= cycle_cnt + 1'b1;
            exe_seq <= dec_seq;
            exe_issue <= dec_issue;
            ret_seq <= exe_seq;
            ret_issue <= exe_issue;
        end
    end

    // retire cycle is simply the count now
    assign ret_cycle = cycle_cnt;

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/1ps

module result_stage import pipe_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic              res_valid,
    input  logic [word_w-1:0] res_data,
    input  logic [addr_w-1:0] res_rd,
    input  logic              res_we,
    input  logic [addr_w-1:0] rf_addr_a,
    input  logic [addr_w-1:0] rf_addr_b,
    output logic [word_w-1:0] rf_data_a,
    output logic [word_w-1:0] rf_data_b
);

    // architectural registers
    logic [word_w-1:0] regs [reg_cnt];
    // writeback strobe
    logic              wr_en;

    ////////////////////
    // writeback
    ////////////////////

    // retire record leaves on the next moving edge
    // a stalled record holds and writes once
    assign wr_en = advance & res_valid & res_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < reg_cnt; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[res_rd] <= res_data;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // write first, bypass the value landing this edge
    assign rf_data_a = (wr_en && res_rd == rf_addr_a) ? res_data : regs[rf_addr_a];
    assign rf_data_b = (wr_en && res_rd == rf_addr_b) ? res_data : regs[rf_addr_b];

endmodule

// File: verilog/trace_core.sv
`timescale 1ns/1ps

module trace_core import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [word_w-1:0]  instr,
    input  logic               stall,
    input  logic               flush,
    output logic               retire_valid,
    output logic [addr_w-1:0]  retire_rd,
    output logic [word_w-1:0]  retire_data,
    output logic               retire_we,
    output logic [seq_w-1:0]   retire_seq,
    output logic [stamp_w-1:0] retire_issue,
    output logic [stamp_w-1:0] retire_cycle
);

    // pipe control
    logic              advance;
    logic              accept;
    logic              exe_valid;

    // decode to execute
    logic [word_w-1:0] op_a;
    logic [word_w-1:0] op_b;
    logic [fn_w-1:0]   alu_fn;
    logic [addr_w-1:0] dst;
    logic              write_en;

    // forwarding from execute
    logic [word_w-1:0] alu_fwd;
    logic [addr_w-1:0] exe_rd;
    logic              exe_we;

    // register file reads
    logic [addr_w-1:0] rf_addr_a;
    logic [addr_w-1:0] rf_addr_b;
    logic [word_w-1:0] rf_data_a;
    logic [word_w-1:0] rf_data_b;

    // strobe only counts when the pipe moves
    assign accept = instr_valid & advance;

    ////////////////////
    // instances
    ////////////////////

    // dec_valid stays inside the tracker
    pipeline_tracker tracker0 (
        .clk(clk), .rst(rst), .accept(accept), .stall(stall), .flush(flush),
        .advance(advance), .dec_valid(), .exe_valid(exe_valid), .res_valid(retire_valid),
        .ret_seq(retire_seq), .ret_issue(retire_issue), .ret_cycle(retire_cycle)
    );

    decode_stage decode0 (
        .clk(clk), .rst(rst), .advance(advance), .accept(accept), .instr(instr),
        .exe_valid(exe_valid), .res_valid(retire_valid), .alu_fwd(alu_fwd),
        .exe_rd(exe_rd), .exe_we(exe_we), .res_data(retire_data), .res_rd(retire_rd),
        .res_we(retire_we), .rf_addr_a(rf_addr_a), .rf_addr_b(rf_addr_b),
        .rf_data_a(rf_data_a), .rf_data_b(rf_data_b), .op_a(op_a), .op_b(op_b),
        .alu_fn(alu_fn), .dst(dst), .write_en(write_en)
    );

    // result registers double as the retire record
    execute_stage execute0 (
        .clk(clk), .rst(rst), .advance(advance), .op_a(op_a), .op_b(op_b),
        .alu_fn(alu_fn), .dst(dst), .write_en(write_en), .alu_fwd(alu_fwd),
        .exe_rd(exe_rd), .exe_we(exe_we), .res_data(retire_data), .res_rd(retire_rd),
        .res_we(retire_we)
    );

    result_stage result0 (
        .clk(clk), .rst(rst), .advance(advance), .res_valid(retire_valid),
        .res_data(retire_data), .res_rd(retire_rd), .res_we(retire_we),
        .rf_addr_a(rf_addr_a), .rf_addr_b(rf_addr_b),
        .rf_data_a(rf_data_a), .rf_data_b(rf_data_b)
    );

endmodule
